// ==== design/rv_isa_pkg.sv ====
// RV32I encodings: major opcodes, ALU functions, write-back and next-PC selects
// and the funct3 values for memory widths and branch conditions
package rv_isa_pkg;

  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_system = 7'b1110011,
    op_fence  = 7'b0001111
  } opcode_t;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_t;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_t;
  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump} pc_sel_t;

  typedef logic [2:0] funct3_t;

  localparam funct3_t f3_b    = 3'b000; // Load and store widths
  localparam funct3_t f3_h    = 3'b001;
  localparam funct3_t f3_w    = 3'b010;
  localparam funct3_t f3_bu   = 3'b100;
  localparam funct3_t f3_hu   = 3'b101;
  localparam funct3_t f3_beq  = 3'b000; // Branch conditions
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

// ==== design/rv_core_pkg.sv ====
// Core widths and memory map
package rv_core_pkg;

  typedef logic [31:0] word_t;     // Data or address word
  typedef logic [4:0]  reg_addr_t; // Register index
  typedef logic [31:0] inst_t;     // One instruction

  // UART transmit data register
  localparam word_t uart_addr = 32'h0000_fff0;

endpackage

// ==== design/issue_check.sv ====
// Pairing checker for the two fetched instructions
module issue_check import rv_core_pkg::*; import rv_isa_pkg::*; (
  input  inst_t inst_1,
  input  inst_t inst_2,
  output logic  pair_ok
);

  opcode_t   op_1;
  opcode_t   op_2;
  reg_addr_t rd_1;
  reg_addr_t rs1_2;
  reg_addr_t rs2_2;
  logic      first_ctrl;
  logic      second_mem;
  logic      writes_rd_1;
  logic      reads_rs1_2;
  logic      reads_rs2_2;
  logic      hazard;

  assign op_1  = opcode_t'(inst_1[6:0]);
  assign op_2  = opcode_t'(inst_2[6:0]);
  assign rd_1  = inst_1[11:7];
  assign rs1_2 = inst_2[19:15];
  assign rs2_2 = inst_2[24:20];

  // Control flow must close the bundle
  assign first_ctrl = op_1 inside {op_branch, op_jal, op_jalr, op_system};
  assign second_mem = op_2 inside {op_load, op_store}; // Memory port is slot 1 only

  assign writes_rd_1 = (rd_1 != '0) &&
                       (op_1 inside {op_reg, op_imm, op_load, op_lui, op_auipc,
                                     op_jal, op_jalr});
  assign reads_rs1_2 = op_2 inside {op_reg, op_imm, op_load, op_store, op_branch,
                                    op_jalr};
  assign reads_rs2_2 = op_2 inside {op_reg, op_store, op_branch};

  // RAW dependency inside the bundle
  assign hazard = writes_rd_1 &&
                  ((reads_rs1_2 && (rs1_2 == rd_1)) ||
                   (reads_rs2_2 && (rs2_2 == rd_1)));

  assign pair_ok = !(first_ctrl || second_mem || hazard);

endmodule

// ==== design/inst_decode.sv ====
// Instruction decoder: register fields, immediate and datapath controls
module inst_decode import rv_core_pkg::*; import rv_isa_pkg::*; (
  input  inst_t     inst,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_t   alu_op,
  output funct3_t   funct3,
  output logic      op1_pc,
  output logic      op2_imm,
  output logic      mem_write,
  output logic      mem_read,
  output logic      rf_wen,
  output wb_sel_t   wb_sel,
  output pc_sel_t   pc_sel
);

  opcode_t opcode;
  word_t   i_imm;
  word_t   s_imm;
  word_t   b_imm;
  word_t   u_imm;
  word_t   j_imm;
  logic    writes;

  assign opcode = opcode_t'(inst[6:0]);
  assign rd     = inst[11:7];
  assign rs2    = inst[24:20];
  assign funct3 = inst[14:12];

  assign i_imm = {{20{inst[31]}}, inst[31:20]};
  assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign u_imm = {inst[31:12], 12'b0};
  assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign rf_wen = writes && (rd != '0);

  always_comb begin
    rs1       = inst[19:15];
    imm       = i_imm;
    alu_op    = alu_add;
    op1_pc    = 1'b0;
    op2_imm   = 1'b1;
    mem_write = 1'b0;
    mem_read  = 1'b0;
    writes    = 1'b0;
    wb_sel    = wb_alu;
    pc_sel    = pc_seq;
    case (opcode)
      op_reg: begin
        alu_op  = alu_op_t'({inst[30], inst[14:12]});
        op2_imm = 1'b0;
        writes  = 1'b1;
      end
      op_imm: begin
        // funct7[5] only selects SRAI among the immediate forms
        if (inst[14:12] == 3'b101) alu_op = alu_op_t'({inst[30], inst[14:12]});
        else alu_op = alu_op_t'({1'b0, inst[14:12]});
        writes = 1'b1;
      end
      op_load: begin
        mem_read = 1'b1;
        writes   = 1'b1;
        wb_sel   = wb_mem;
      end
      op_store: begin
        imm       = s_imm;
        mem_write = 1'b1;
      end
      op_branch: begin
        imm    = b_imm;
        op1_pc = 1'b1; // ALU forms the target
        pc_sel = pc_branch;
      end
      op_lui: begin
        rs1    = '0; // x0 + imm
        imm    = u_imm;
        writes = 1'b1;
      end
      op_auipc: begin
        rs1    = '0;
        imm    = u_imm;
        op1_pc = 1'b1;
        writes = 1'b1;
      end
      op_jal: begin
        rs1    = '0;
        imm    = j_imm;
        op1_pc = 1'b1;
        writes = 1'b1;
        wb_sel = wb_link;
        pc_sel = pc_jump;
      end
      op_jalr: begin
        writes = 1'b1;
        wb_sel = wb_link;
        pc_sel = pc_jump;
      end
      default: begin
        rs1 = '0; // System, fence and all-zero words act as no-ops
      end
    endcase
  end

endmodule

// ==== design/reg_file.sv ====
// Register file, 32 x 32 bits, four read ports and two write ports
module reg_file import rv_core_pkg::*; (
  input  logic      clock,
  input  logic      reset_n,
  input  reg_addr_t rs1_1,
  input  reg_addr_t rs2_1,
  input  reg_addr_t rs1_2,
  input  reg_addr_t rs2_2,
  output word_t     rdata1_1,
  output word_t     rdata2_1,
  output word_t     rdata1_2,
  output word_t     rdata2_2,
  input  logic      wen_1,
  input  logic      wen_2,
  input  reg_addr_t waddr_1,
  input  reg_addr_t waddr_2,
  input  word_t     wdata_1,
  input  word_t     wdata_2
);

  word_t regs [32];

  assign rdata1_1 = (rs1_1 == '0) ? '0 : regs[rs1_1]; // x0 reads zero
  assign rdata2_1 = (rs2_1 == '0) ? '0 : regs[rs2_1];
  assign rdata1_2 = (rs1_2 == '0) ? '0 : regs[rs1_2];
  assign rdata2_2 = (rs2_2 == '0) ? '0 : regs[rs2_2];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      if (wen_1 && (waddr_1 != '0)) regs[waddr_1] <= wdata_1;
      if (wen_2 && (waddr_2 != '0)) regs[waddr_2] <= wdata_2; // Slot 2 wins
    end
  end

endmodule

// ==== design/exec_unit.sv ====
// Execute stage of one slot: operand select, ALU and branch decision
module exec_unit import rv_core_pkg::*; import rv_isa_pkg::*; (
  input  alu_op_t alu_op,
  input  logic    op1_pc,
  input  logic    op2_imm,
  input  word_t   pc,
  input  word_t   rdata1,
  input  word_t   rdata2,
  input  word_t   imm,
  input  funct3_t funct3,
  input  pc_sel_t pc_sel,
  output word_t   result,
  output logic    take_jump
);

  word_t opa;
  word_t opb;
  logic  cond;

  assign opa = op1_pc  ? pc  : rdata1;
  assign opb = op2_imm ? imm : rdata2;

  always_comb begin
    case (alu_op)
      alu_add:  result = opa + opb;
      alu_sub:  result = opa - opb;
      alu_sll:  result = opa << opb[4:0];
      alu_slt:  result = word_t'($signed(opa) < $signed(opb));
      alu_sltu: result = word_t'(opa < opb);
      alu_xor:  result = opa ^ opb;
      alu_srl:  result = opa >> opb[4:0];
      alu_sra:  result = $signed(opa) >>> opb[4:0];
      alu_or:   result = opa | opb;
      alu_and:  result = opa & opb;
      default:  result = '0; // Undefined funct7 patterns
    endcase
  end

  // Compare register values, never the ALU operands
  always_comb begin
    case (funct3)
      f3_beq:  cond = (rdata1 == rdata2);
      f3_bne:  cond = (rdata1 != rdata2);
      f3_blt:  cond = ($signed(rdata1) < $signed(rdata2));
      f3_bge:  cond = ($signed(rdata1) >= $signed(rdata2));
      f3_bltu: cond = (rdata1 < rdata2);
      f3_bgeu: cond = (rdata1 >= rdata2);
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    case (pc_sel)
      pc_branch: take_jump = cond;
      pc_jump:   take_jump = 1'b1;
      default:   take_jump = 1'b0;
    endcase
  end

endmodule

// ==== design/data_memory.sv ====
// Byte-addressed data memory with sized loads, byte-lane stores
// and the memory-mapped UART transmit register
module data_memory import rv_core_pkg::*; import rv_isa_pkg::*; #(
  parameter int dmem_words = 1024
) (
  input  logic       clock,
  input  logic       reset_n,
  input  logic       mem_write,
  input  logic       mem_read,
  input  funct3_t    funct3,
  input  word_t      addr,
  input  word_t      store_data,
  output word_t      load_data,
  output logic       uart_valid,
  output logic [7:0] uart_data
);

  localparam int idx_w = $clog2(dmem_words);

  word_t            mem [dmem_words];
  logic [idx_w-1:0] idx;
  logic [1:0]       lane;
  word_t            rd_word;
  logic [7:0]       rd_byte;
  logic [15:0]      rd_half;
  logic             is_uart;

  initial begin
    for (int i = 0; i < dmem_words; i++) mem[i] = '0;
  end

  assign idx     = addr[idx_w+1:2];
  assign lane    = addr[1:0];
  assign rd_word = mem[idx];
  assign rd_byte = rd_word[8*lane +: 8];
  assign rd_half = rd_word[16*lane[1] +: 16];
  assign is_uart = (addr == uart_addr);

  always_comb begin
    load_data = '0; // Misaligned or no load
    if (mem_read) begin
      case (funct3)
        f3_b:    load_data = {{24{rd_byte[7]}}, rd_byte};
        f3_bu:   load_data = {24'b0, rd_byte};
        f3_h:    if (!lane[0]) load_data = {{16{rd_half[15]}}, rd_half};
        f3_hu:   if (!lane[0]) load_data = {16'b0, rd_half};
        f3_w:    if (lane == 2'b00) load_data = rd_word;
        default: load_data = '0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (mem_write && !is_uart) begin
      case (funct3)
        f3_b: mem[idx][8*lane +: 8] <= store_data[7:0];
        f3_h: if (!lane[0]) mem[idx][16*lane[1] +: 16] <= store_data[15:0];
        f3_w: if (lane == 2'b00) mem[idx] <= store_data;
        default: ;
      endcase
    end
  end

  // UART byte strobe lasts one cycle
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      uart_valid <= 1'b0;
    end else begin
      uart_valid <= mem_write && is_uart;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_write && is_uart) uart_data <= store_data[7:0];
  end

endmodule

// ==== design/rv32i_dual_core.sv ====
// Dual-issue RV32I core top: PC, fetch port, pairing, write-back and next PC
module rv32i_dual_core import rv_core_pkg::*; import rv_isa_pkg::*; #(
  parameter int dmem_words = 1024
) (
  input  logic       clock,
  input  logic       reset_n,
  output word_t      fetch_pc,
  input  inst_t      inst_1,
  input  inst_t      inst_2,
  output logic       commit_pair,
  output logic       commit_en_1,
  output logic       commit_en_2,
  output reg_addr_t  commit_addr_1,
  output reg_addr_t  commit_addr_2,
  output word_t      commit_data_1,
  output word_t      commit_data_2,
  output logic       uart_valid,
  output logic [7:0] uart_data
);

  word_t     pc;
  word_t     pc_2;
  word_t     next_pc;
  logic      pair_ok;
  inst_t     inst_2_issued;
  reg_addr_t rs1_1, rs2_1, rd_1, rs1_2, rs2_2, rd_2;
  word_t     imm_1, imm_2;
  alu_op_t   alu_op_1, alu_op_2;
  funct3_t   funct3_1, funct3_2;
  logic      op1_pc_1, op2_imm_1, op1_pc_2, op2_imm_2;
  logic      mem_write_1, mem_read_1;
  logic      rf_wen_1, rf_wen_2;
  wb_sel_t   wb_sel_1, wb_sel_2;
  pc_sel_t   pc_sel_1, pc_sel_2;
  word_t     rdata1_1, rdata2_1, rdata1_2, rdata2_2;
  word_t     result_1, result_2;
  logic      take_jump_1, take_jump_2;
  word_t     load_data;
  word_t     wdata_1, wdata_2;

  function automatic word_t wb_mux(wb_sel_t sel, word_t alu, word_t load, word_t link);
    case (sel)
      wb_mem:  return load;
      wb_link: return link;
      default: return alu;
    endcase
  endfunction

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  assign fetch_pc = pc;
  assign pc_2     = pc + 32'd4;

  issue_check u_issue (.inst_1(inst_1), .inst_2(inst_2), .pair_ok(pair_ok));

  assign inst_2_issued = pair_ok ? inst_2 : '0; // Unpaired slot 2 runs a no-op

  inst_decode u_dec_1 (
    .inst(inst_1), .rs1(rs1_1), .rs2(rs2_1), .rd(rd_1), .imm(imm_1),
    .alu_op(alu_op_1), .funct3(funct3_1), .op1_pc(op1_pc_1), .op2_imm(op2_imm_1),
    .mem_write(mem_write_1), .mem_read(mem_read_1), .rf_wen(rf_wen_1),
    .wb_sel(wb_sel_1), .pc_sel(pc_sel_1)
  );

  inst_decode u_dec_2 (
    .inst(inst_2_issued), .rs1(rs1_2), .rs2(rs2_2), .rd(rd_2), .imm(imm_2),
    .alu_op(alu_op_2), .funct3(funct3_2), .op1_pc(op1_pc_2), .op2_imm(op2_imm_2),
    .mem_write(), .mem_read(), .rf_wen(rf_wen_2),
    .wb_sel(wb_sel_2), .pc_sel(pc_sel_2)
  );

  reg_file u_regs (
    .clock(clock), .reset_n(reset_n),
    .rs1_1(rs1_1), .rs2_1(rs2_1), .rs1_2(rs1_2), .rs2_2(rs2_2),
    .rdata1_1(rdata1_1), .rdata2_1(rdata2_1), .rdata1_2(rdata1_2), .rdata2_2(rdata2_2),
    .wen_1(rf_wen_1), .wen_2(rf_wen_2), .waddr_1(rd_1), .waddr_2(rd_2),
    .wdata_1(wdata_1), .wdata_2(wdata_2)
  );

  exec_unit u_exec_1 (
    .alu_op(alu_op_1), .op1_pc(op1_pc_1), .op2_imm(op2_imm_1), .pc(pc),
    .rdata1(rdata1_1), .rdata2(rdata2_1), .imm(imm_1), .funct3(funct3_1),
    .pc_sel(pc_sel_1), .result(result_1), .take_jump(take_jump_1)
  );

  exec_unit u_exec_2 (
    .alu_op(alu_op_2), .op1_pc(op1_pc_2), .op2_imm(op2_imm_2), .pc(pc_2),
    .rdata1(rdata1_2), .rdata2(rdata2_2), .imm(imm_2), .funct3(funct3_2),
    .pc_sel(pc_sel_2), .result(result_2), .take_jump(take_jump_2)
  );

  data_memory #(.dmem_words(dmem_words)) u_dmem (
    .clock(clock), .reset_n(reset_n), .mem_write(mem_write_1), .mem_read(mem_read_1),
    .funct3(funct3_1), .addr(result_1), .store_data(rdata2_1), .load_data(load_data),
    .uart_valid(uart_valid), .uart_data(uart_data)
  );

  assign wdata_1 = wb_mux(wb_sel_1, result_1, load_data, pc_2);
  assign wdata_2 = wb_mux(wb_sel_2, result_2, load_data, pc + 32'd8);

  always_comb begin
    if (pair_ok) next_pc = take_jump_2 ? {result_2[31:1], 1'b0} : pc + 32'd8;
    else next_pc = take_jump_1 ? {result_1[31:1], 1'b0} : pc_2;
  end

  assign commit_pair   = pair_ok;
  assign commit_en_1   = rf_wen_1;
  assign commit_en_2   = rf_wen_2;
  assign commit_addr_1 = rd_1;
  assign commit_addr_2 = rd_2;
  assign commit_data_1 = wdata_1;
  assign commit_data_2 = wdata_2;

endmodule

// ==== tb/tb_ref_model.svh ====
// Reference RV32I model: register, memory and PC state,
// the pairing rule and a one-instruction step
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

  localparam logic [31:0] uart_port = 32'h0000_fff0;

  logic [31:0] m_regs [32];
  logic [7:0]  m_mem [4096]; // Byte view, wraps like a 1024-word memory
  logic [31:0] m_pc;

  task automatic model_reset();
    m_pc = '0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < 4096; i++) m_mem[i] = '0;
  endtask

  // Second instruction may issue beside the first
  function automatic logic pair_rule(input logic [31:0] i1, input logic [31:0] i2);
    logic [6:0] o1;
    logic [6:0] o2;
    logic       wr1;
    logic       rd_rs1;
    logic       rd_rs2;
    o1 = i1[6:0];
    o2 = i2[6:0];
    if (o1 inside {7'h63, 7'h6f, 7'h67, 7'h73}) return 1'b0; // Control closes the bundle
    if (o2 inside {7'h03, 7'h23}) return 1'b0;               // Memory in slot 1 only
    wr1    = (i1[11:7] != 5'd0) && (o1 inside {7'h33, 7'h13, 7'h03, 7'h37, 7'h17});
    rd_rs1 = o2 inside {7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h67};
    rd_rs2 = o2 inside {7'h33, 7'h23, 7'h63};
    if (wr1 && rd_rs1 && (i2[19:15] == i1[11:7])) return 1'b0;
    if (wr1 && rd_rs2 && (i2[24:20] == i1[11:7])) return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = {31'b0, $signed(x) < $signed(y)};
      3'd3: r = {31'b0, x < y};
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) r = $signed(x) >>> y[4:0];
        else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  // Runs one instruction at m_pc and reports its register write and UART byte
  function automatic void ref_step(input logic [31:0] in, output logic wen,
                                   output logic [4:0] rd, output logic [31:0] wd,
                                   output logic uv, output logic [7:0] ub);
    logic [31:0] a, b, addr, next, imm_i, imm_s, imm_b, imm_j;
    logic [11:0] ba;
    logic [2:0]  f3;
    logic        writes;
    logic        taken;
    a     = m_regs[in[19:15]];
    b     = m_regs[in[24:20]];
    f3    = in[14:12];
    rd    = in[11:7];
    imm_i = {{20{in[31]}}, in[31:20]};
    imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
    imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    next   = m_pc + 32'd4;
    writes = 1'b0;
    wd     = '0;
    uv     = 1'b0;
    ub     = '0;
    case (in[6:0])
      7'h33: begin
        wd     = alu_ref(f3, in[30], a, b);
        writes = 1'b1;
      end
      7'h13: begin
        wd     = alu_ref(f3, (f3 == 3'd5) && in[30], a, imm_i); // Only srai uses bit 30
        writes = 1'b1;
      end
      7'h37: begin
        wd     = {in[31:12], 12'b0};
        writes = 1'b1;
      end
      7'h17: begin
        wd     = m_pc + {in[31:12], 12'b0};
        writes = 1'b1;
      end
      7'h6f: begin
        wd     = m_pc + 32'd4;
        writes = 1'b1;
        next   = m_pc + imm_j;
      end
      7'h67: begin
        wd     = m_pc + 32'd4;
        writes = 1'b1;
        next   = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) next = m_pc + imm_b;
      end
      7'h03: begin
        addr   = a + imm_i;
        ba     = addr[11:0];
        writes = 1'b1;
        case (f3)
          3'd0: wd = {{24{m_mem[ba][7]}}, m_mem[ba]};
          3'd1: wd = {{16{m_mem[ba + 12'd1][7]}}, m_mem[ba + 12'd1], m_mem[ba]};
          3'd2: wd = {m_mem[ba + 12'd3], m_mem[ba + 12'd2], m_mem[ba + 12'd1], m_mem[ba]};
          3'd4: wd = {24'b0, m_mem[ba]};
          3'd5: wd = {16'b0, m_mem[ba + 12'd1], m_mem[ba]};
          default: wd = '0;
        endcase
      end
      7'h23: begin
        addr = a + imm_s;
        ba   = addr[11:0];
        if (addr == uart_port) begin
          uv = 1'b1;
          ub = b[7:0];
        end else begin
          m_mem[ba] = b[7:0];
          if (f3 != 3'd0) m_mem[ba + 12'd1] = b[15:8];
          if (f3 == 3'd2) begin
            m_mem[ba + 12'd2] = b[23:16];
            m_mem[ba + 12'd3] = b[31:24];
          end
        end
      end
      default: ; // Fence, system and all-zero words change nothing
    endcase
    wen = writes && (rd != 5'd0);
    if (wen) m_regs[rd] = wd;
    m_pc = next;
  endfunction

`endif

// ==== tb/tb_core.sv ====
// Testbench for the dual-issue core: clock, reset, fetch port,
// per-bundle commit and UART compare against the reference model
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clock;
  logic        reset_n;
  logic [31:0] fetch_pc;
  logic [31:0] inst_1;
  logic [31:0] inst_2;
  logic        commit_pair;
  logic        commit_en_1;
  logic        commit_en_2;
  logic [4:0]  commit_addr_1;
  logic [4:0]  commit_addr_2;
  logic [31:0] commit_data_1;
  logic [31:0] commit_data_2;
  logic        uart_valid;
  logic [7:0]  uart_data;

  logic [31:0] prog [64];
  int          checks [6];
  int          fails [6];
  string       test_names [6] = '{"reset", "alu", "pairing", "load_store", "control", "uart"};

  `include "tb_ref_model.svh"

  rv32i_dual_core #(.dmem_words(1024)) dut0 (
    .clock(clock), .reset_n(reset_n), .fetch_pc(fetch_pc),
    .inst_1(inst_1), .inst_2(inst_2), .commit_pair(commit_pair),
    .commit_en_1(commit_en_1), .commit_en_2(commit_en_2),
    .commit_addr_1(commit_addr_1), .commit_addr_2(commit_addr_2),
    .commit_data_1(commit_data_1), .commit_data_2(commit_data_2),
    .uart_valid(uart_valid), .uart_data(uart_data)
  );

  // Combinational fetch of two consecutive words
  assign inst_1 = prog[fetch_pc[7:2]];
  assign inst_2 = prog[fetch_pc[7:2] + 6'd1];

  always #10 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int category_of(input logic [31:0] inst);
    if (inst[6:0] inside {7'h03, 7'h23}) return 3;
    if (inst[6:0] inside {7'h63, 7'h6f, 7'h67}) return 4;
    return 1;
  endfunction

  task automatic compare_value(input int cat, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks[cat]++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      fails[cat]++;
    end
  endtask

  task automatic verify_commit(input string sfx, input logic [31:0] inst, input logic got_en,
                               input logic [4:0] got_addr, input logic [31:0] got_data,
                               input logic exp_en, input logic [4:0] exp_addr,
                               input logic [31:0] exp_data);
    int cat;
    cat = category_of(inst);
    compare_value(cat, {"commit_en_", sfx}, got_en, exp_en);
    if (exp_en) begin
      compare_value(cat, {"commit_addr_", sfx}, got_addr, exp_addr);
      compare_value(cat, {"commit_data_", sfx}, got_data, exp_data);
    end
  endtask

  initial begin
    logic [31:0] seed, i1, i2, wd_a, wd_b;
    logic [4:0]  rd_a, rd_b;
    logic [7:0]  ub_a, ub_b, exp_ub;
    logic        exp_pair, wen_a, wen_b, uv_a, uv_b, exp_uv;
    int          cycles, uart_seen, total_checks, total_fails;
    clock   = 1'b0;
    reset_n = 1'b0;
    for (int i = 0; i < 64; i++) prog[i] = 32'h0000_0013;
    $readmemh("prog.hex", prog);
    seed = 32'h6de4_e744;
    for (int r = 1; r <= 4; r++) begin // x1..x4 from the LCG
      seed = lcg_next(seed);
      // Upper part rounded up when the addi immediate is negative
      prog[34 + 2 * r] = {seed[31:12] + {19'b0, seed[11]}, 5'(r), 7'h37};
      prog[35 + 2 * r] = {seed[11:0], 5'(r), 3'b000, 5'(r), 7'h13};
    end
    model_reset();
    repeat (2) @(negedge clock);
    reset_n = 1'b1;

    compare_value(0, "fetch_pc", fetch_pc, 32'h0);
    compare_value(0, "uart_valid", uart_valid, 32'h0);
    compare_value(0, "commit_pair", commit_pair, pair_rule(prog[0], prog[1]));
    $display("test %s: %0d checks, %0d failed", test_names[0], checks[0], fails[0]);

    exp_uv    = 1'b0;
    exp_ub    = '0;
    cycles    = 0;
    uart_seen = 0;
    while (uart_seen < 3 && cycles < 2000) begin
      compare_value(4, "fetch_pc", fetch_pc, m_pc);
      compare_value(5, "uart_valid", uart_valid, exp_uv);
      if (exp_uv) begin
        compare_value(5, "uart_data", uart_data, exp_ub);
        uart_seen++;
      end
      i1       = prog[m_pc[7:2]];
      i2       = prog[m_pc[7:2] + 6'd1];
      exp_pair = pair_rule(i1, i2);
      compare_value(2, "commit_pair", commit_pair, exp_pair);
      ref_step(i1, wen_a, rd_a, wd_a, uv_a, ub_a);
      verify_commit("1", i1, commit_en_1, commit_addr_1, commit_data_1, wen_a, rd_a, wd_a);
      wen_b = 1'b0;
      rd_b  = '0;
      wd_b  = '0;
      uv_b  = 1'b0;
      ub_b  = '0;
      if (exp_pair) ref_step(i2, wen_b, rd_b, wd_b, uv_b, ub_b);
      verify_commit("2", exp_pair ? i2 : 32'h0, commit_en_2, commit_addr_2, commit_data_2,
                    wen_b, rd_b, wd_b);
      exp_uv = uv_a | uv_b; // UART strobe shows one cycle later
      exp_ub = uv_a ? ub_a : ub_b;
      @(negedge clock);
      cycles++;
    end
    if (uart_seen < 3) begin
      $display("Timeout: only %0d of 3 UART bytes seen after %0d cycles", uart_seen, cycles);
      fails[5]++;
    end

    total_checks = checks[0];
    total_fails  = fails[0];
    for (int t = 1; t < 6; t++) begin
      $display("test %s: %0d checks, %0d failed", test_names[t], checks[t], fails[t]);
      total_checks += checks[t];
      total_fails  += fails[t];
    end
    $display("total: %0d checks, %0d failed", total_checks, total_fails);
    if (total_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/issue_check.sv
design/inst_decode.sv
design/reg_file.sv
design/exec_unit.sv
design/data_memory.sv
design/rv32i_dual_core.sv
+incdir+tb
tb/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== prog.hex ====
// One 32-bit instruction word per line, word 0 at address 0
// Words 36 to 43 are replaced by the testbench with lui/addi operand loads
0900006f
002082b3
40208333
002093b3
0020a433
0020b4b3
0041c533
0041d5b3
4041d633
0062e6b3
0046f733
ffb08793
4071d813
12345897
10000913
00192023
00291223
00390323
00092983
00491a03
00495a83
00690b03
00194b83
00108463
00100c13
00109463
00800cef
00200c13
00cc8d67
00300c13
00010db7
ff0d8d93
005d8023
013d8023
01ad8023
0000006f
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
f55ff06f
